//--- flist.f
+incdir+.
regif_pkg.sv
tick_timer.sv
vram_addr_channel.sv
host_reg_decode.sv
mem_access_ctrl.sv
reg_interface_top.sv
tb_reg_interface.sv

//--- host_reg_decode.sv
/*
 * Host register decoder
 *   byte writes to channel registers and SYS_CTRL
 *   even byte latch for DATA / RW_DATA
 *   registered VRAM access request on odd byte triggers
 *   combinational readback byte mux
 */
`timescale 1ns/1ps

module host_reg_decode import regif_pkg::*; (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                bus_wr_i,
    input  logic                bus_rd_i,
    input  reg_num_t            bus_reg_num_i,
    input  logic                bus_bytesel_i,   // 0 = high byte
    input  byte_t               bus_data_i,
    output byte_t               bus_data_o,
    input  word_t               chan_addr_i [NUM_CHAN],
    input  word_t               chan_incr_i [NUM_CHAN],
    input  word_t               chan_rdata_i [NUM_CHAN],
    input  logic                busy_i,
    input  word_t               timer_i,
    output logic [NUM_CHAN-1:0] incr_hi_we_o,
    output logic [NUM_CHAN-1:0] incr_lo_we_o,
    output logic [NUM_CHAN-1:0] addr_hi_we_o,
    output logic [NUM_CHAN-1:0] addr_lo_we_o,
    output byte_t               wr_byte_o,
    output logic                req_valid_o,
    output chan_idx_t           req_chan_o,
    output logic                req_write_o,
    output word_t               req_data_o,
    output wrmask_t             vram_wrmask_o,
    output intr_mask_t          intr_mask_o
);

    logic                wr_even;
    logic                wr_odd;
    logic                rd_odd;
    logic [NUM_CHAN-1:0] incr_sel;    // register number hits a channel incr
    logic [NUM_CHAN-1:0] addr_sel;    // register number hits a channel addr
    byte_t               data_even;   // shared DATA / RW_DATA high byte
    logic                trig;
    chan_idx_t           trig_chan;
    logic                trig_write;
    word_t               rb_word;

    assign wr_even = bus_wr_i && !bus_bytesel_i;
    assign wr_odd  = bus_wr_i && bus_bytesel_i;
    assign rd_odd  = bus_rd_i && bus_bytesel_i;

    always_comb begin
        incr_sel          = '0;
        addr_sel          = '0;
        incr_sel[CHAN_RD] = (bus_reg_num_i == RD_INCR);
        incr_sel[CHAN_WR] = (bus_reg_num_i == WR_INCR);
        incr_sel[CHAN_RW] = (bus_reg_num_i == RW_INCR);
        addr_sel[CHAN_RD] = (bus_reg_num_i == RD_ADDR);
        addr_sel[CHAN_WR] = (bus_reg_num_i == WR_ADDR);
        addr_sel[CHAN_RW] = (bus_reg_num_i == RW_ADDR);
    end

    assign incr_hi_we_o = wr_even ? incr_sel : '0;
    assign incr_lo_we_o = wr_odd  ? incr_sel : '0;
    assign addr_hi_we_o = wr_even ? addr_sel : '0;
    assign addr_lo_we_o = wr_odd  ? addr_sel : '0;
    assign wr_byte_o    = bus_data_i;

    // odd byte events that start a VRAM access
    always_comb begin
        trig       = 1'b0;
        trig_chan  = CHAN_RD;
        trig_write = 1'b0;
        if (wr_odd) begin
            case (bus_reg_num_i)
                RD_ADDR: begin
                    trig = 1'b1;             // pre-read at new address
                end
                RW_ADDR: begin
                    trig      = 1'b1;
                    trig_chan = CHAN_RW;
                end
                DATA: begin
                    trig       = 1'b1;
                    trig_chan  = CHAN_WR;
                    trig_write = 1'b1;
                end
                RW_DATA: begin
                    trig       = 1'b1;
                    trig_chan  = CHAN_RW;
                    trig_write = 1'b1;
                end
                default: ;
            endcase
        end else if (rd_odd) begin
            trig      = (bus_reg_num_i == DATA) || (bus_reg_num_i == RW_DATA);
            trig_chan = (bus_reg_num_i == RW_DATA) ? CHAN_RW : CHAN_RD;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            req_valid_o   <= 1'b0;
            intr_mask_o   <= '0;
            vram_wrmask_o <= WRMASK_RESET;
        end else begin
            req_valid_o <= trig && !busy_i;  // dropped while busy
            if (wr_even && bus_reg_num_i == SYS_CTRL) begin
                intr_mask_o <= bus_data_i[3:0];
            end
            if (wr_odd && bus_reg_num_i == SYS_CTRL) begin
                vram_wrmask_o <= bus_data_i[3:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_even && (bus_reg_num_i == DATA || bus_reg_num_i == RW_DATA)) begin
            data_even <= bus_data_i;
        end
        if (trig) begin
            req_chan_o  <= trig_chan;
            req_write_o <= trig_write;
            req_data_o  <= {data_even, bus_data_i};
        end
    end

    always_comb begin
        case (bus_reg_num_i)
            RD_INCR:  rb_word = chan_incr_i[CHAN_RD];
            RD_ADDR:  rb_word = chan_addr_i[CHAN_RD];
            WR_INCR:  rb_word = chan_incr_i[CHAN_WR];
            WR_ADDR:  rb_word = chan_addr_i[CHAN_WR];
            DATA:     rb_word = chan_rdata_i[CHAN_RD];
            SYS_CTRL: rb_word = {4'b0, intr_mask_o, busy_i, 3'b0, vram_wrmask_o};
            TIMER:    rb_word = timer_i;
            RW_INCR:  rb_word = chan_incr_i[CHAN_RW];
            RW_ADDR:  rb_word = chan_addr_i[CHAN_RW];
            RW_DATA:  rb_word = chan_rdata_i[CHAN_RW];
            default:  rb_word = '0;
        endcase
    end

    assign bus_data_o = bus_bytesel_i ? rb_word[7:0] : rb_word[15:8];

endmodule

//--- mem_access_ctrl.sv
/*
 * VRAM access controller
 *   accepts one request at a time
 *   holds select, address and data until ack
 *   steps the owning channel and hands back read data
 */
`timescale 1ns/1ps

module mem_access_ctrl import regif_pkg::*; (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                req_valid_i,
    input  chan_idx_t           req_chan_i,
    input  logic                req_write_i,
    input  word_t               req_data_i,
    input  word_t               chan_addr_i [NUM_CHAN],
    input  logic                vram_ack_i,
    input  word_t               vram_rdata_i,
    output logic                vram_sel_o,
    output logic                vram_wr_o,
    output word_t               vram_addr_o,
    output word_t               vram_data_o,
    output logic [NUM_CHAN-1:0] step_o,
    output logic [NUM_CHAN-1:0] rdata_we_o,
    output word_t               rdata_o,
    output logic                busy_o
);

    chan_idx_t cur_chan;  // owner of the access in flight
    logic      done;

    assign done = vram_sel_o && vram_ack_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o <= 1'b0;
            vram_wr_o  <= 1'b0;
            cur_chan   <= CHAN_RD;
        end else if (!vram_sel_o) begin
            if (req_valid_i) begin
                vram_sel_o <= 1'b1;
                vram_wr_o  <= req_write_i;
                cur_chan   <= req_chan_i;
            end
        end else if (vram_ack_i) begin
            vram_sel_o <= 1'b0;        // drop at the ack edge
            vram_wr_o  <= 1'b0;
        end
    end

    // address and data held stable while selected
    always_ff @(posedge clk) begin
        if (!vram_sel_o && req_valid_i) begin
            vram_addr_o <= chan_addr_i[req_chan_i];
            vram_data_o <= req_data_i;
        end
    end

    always_comb begin
        step_o     = '0;
        rdata_we_o = '0;
        if (done) begin
            step_o[cur_chan]     = 1'b1;
            rdata_we_o[cur_chan] = !vram_wr_o;
        end
    end

    assign rdata_o = vram_rdata_i;
    assign busy_o  = req_valid_i || vram_sel_o;

endmodule

//--- reg_interface_top.sv
/*
 * Video controller host register block
 *   register decoder, three VRAM address channels,
 *   VRAM access controller and timer
 */
`timescale 1ns/1ps

module reg_interface_top import regif_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       bus_wr_i,
    input  logic       bus_rd_i,
    input  reg_num_t   bus_reg_num_i,
    input  logic       bus_bytesel_i,
    input  byte_t      bus_data_i,
    output byte_t      bus_data_o,
    output logic       vram_sel_o,
    output logic       vram_wr_o,
    output word_t      vram_addr_o,
    output word_t      vram_data_o,
    output wrmask_t    vram_wrmask_o,
    input  logic       vram_ack_i,
    input  word_t      vram_rdata_i,
    output intr_mask_t intr_mask_o
);

    word_t               chan_addr [NUM_CHAN];
    word_t               chan_incr [NUM_CHAN];
    word_t               chan_rdata [NUM_CHAN];
    logic [NUM_CHAN-1:0] incr_hi_we;
    logic [NUM_CHAN-1:0] incr_lo_we;
    logic [NUM_CHAN-1:0] addr_hi_we;
    logic [NUM_CHAN-1:0] addr_lo_we;
    byte_t               wr_byte;
    logic [NUM_CHAN-1:0] step;
    logic [NUM_CHAN-1:0] rdata_we;
    word_t               rdata;
    logic                req_valid;
    chan_idx_t           req_chan;
    logic                req_write;
    word_t               req_data;
    logic                busy;
    word_t               timer;

    host_reg_decode u_decode (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_wr_i      (bus_wr_i),
        .bus_rd_i      (bus_rd_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .bus_data_o    (bus_data_o),
        .chan_addr_i   (chan_addr),
        .chan_incr_i   (chan_incr),
        .chan_rdata_i  (chan_rdata),
        .busy_i        (busy),
        .timer_i       (timer),
        .incr_hi_we_o  (incr_hi_we),
        .incr_lo_we_o  (incr_lo_we),
        .addr_hi_we_o  (addr_hi_we),
        .addr_lo_we_o  (addr_lo_we),
        .wr_byte_o     (wr_byte),
        .req_valid_o   (req_valid),
        .req_chan_o    (req_chan),
        .req_write_o   (req_write),
        .req_data_o    (req_data),
        .vram_wrmask_o (vram_wrmask_o),
        .intr_mask_o   (intr_mask_o)
    );

    // RD, WR and RW channels
    for (genvar c = 0; c < NUM_CHAN; c++) begin : g_chan
        vram_addr_channel u_chan (
            .clk          (clk),
            .reset_i      (reset_i),
            .incr_hi_we_i (incr_hi_we[c]),
            .incr_lo_we_i (incr_lo_we[c]),
            .addr_hi_we_i (addr_hi_we[c]),
            .addr_lo_we_i (addr_lo_we[c]),
            .wr_byte_i    (wr_byte),
            .step_i       (step[c]),
            .rdata_we_i   (rdata_we[c]),
            .rdata_i      (rdata),
            .addr_o       (chan_addr[c]),
            .incr_o       (chan_incr[c]),
            .rdata_o      (chan_rdata[c])
        );
    end

    mem_access_ctrl u_mem (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid),
        .req_chan_i   (req_chan),
        .req_write_i  (req_write),
        .req_data_i   (req_data),
        .chan_addr_i  (chan_addr),
        .vram_ack_i   (vram_ack_i),
        .vram_rdata_i (vram_rdata_i),
        .vram_sel_o   (vram_sel_o),
        .vram_wr_o    (vram_wr_o),
        .vram_addr_o  (vram_addr_o),
        .vram_data_o  (vram_data_o),
        .step_o       (step),
        .rdata_we_o   (rdata_we),
        .rdata_o      (rdata),
        .busy_o       (busy)
    );

    tick_timer u_timer (
        .clk     (clk),
        .reset_i (reset_i),
        .timer_o (timer)
    );

endmodule

//--- regif_pkg.sv
/*
 * Register interface package
 *   bus, word and mask types
 *   host register numbers
 *   address channel indices and count
 *   timer divider and write mask reset value
 */
package regif_pkg;

    typedef logic [7:0]  byte_t;      // host bus byte
    typedef logic [15:0] word_t;      // register, address or data word
    typedef logic [3:0]  wrmask_t;    // VRAM nibble write mask
    typedef logic [3:0]  intr_mask_t; // interrupt enables

    // host visible register numbers, others read zero
    typedef enum logic [3:0] {
        RD_INCR  = 4'd2,
        RD_ADDR  = 4'd3,
        WR_INCR  = 4'd4,
        WR_ADDR  = 4'd5,
        DATA     = 4'd6,
        SYS_CTRL = 4'd8,
        TIMER    = 4'd9,
        RW_INCR  = 4'd12,
        RW_ADDR  = 4'd13,
        RW_DATA  = 4'd14
    } reg_num_t;

    typedef logic [1:0] chan_idx_t;

    localparam int        NUM_CHAN = 3;
    localparam chan_idx_t CHAN_RD  = 2'd0;  // pre-read stream
    localparam chan_idx_t CHAN_WR  = 2'd1;  // write stream
    localparam chan_idx_t CHAN_RW  = 2'd2;  // combined stream

    localparam int      TICK_DIV     = 2500;  // 25 MHz clk to 0.1 ms
    localparam wrmask_t WRMASK_RESET = 4'hF;

endpackage

//--- tb_ref_model.svh
/*
 * Testbench helpers
 *   Galois LFSR step and bit draw
 *   expected channel address after n steps
 *   failure report and compare tasks
 */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois form
endfunction

// one LFSR step per bit taken
function automatic int unsigned lfsr_draw(inout logic [31:0] state, input int nbits);
    int unsigned val;
    val = 0;
    for (int i = 0; i < nbits; i++) begin
        val   = (val << 1) | state[0];
        state = lfsr_step(state);
    end
    return val;
endfunction

function automatic word_t ref_addr(input word_t start, input word_t incr, input int unsigned n);
    return word_t'(32'(start) + n * 32'(incr));  // modulo 2^16
endfunction

task automatic fail_msg(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
        fail_msg($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
    end
endtask

task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (exp !== act) begin
        fail_msg($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
endtask

task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
        fail_msg($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
endtask

task automatic check_mask(input string name, input wrmask_t exp, input wrmask_t act);
    if (exp !== act) begin
        fail_msg($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
endtask

`endif

//--- tb_reg_interface.sv
/*
 * Testbench for the video controller host register block
 *   clock, reset and host byte bus tasks
 *   VRAM memory model with random ack delay
 *   VRAM write compare process
 *   register readback, WR/RD/RW streams, busy and timer tests
 */
`timescale 1ns/1ps

module tb_reg_interface import regif_pkg::*; ();

    localparam int NUM_ACC = 8;  // accesses per stream test

    logic       clk;
    logic       reset_i;
    logic       bus_wr_i;
    logic       bus_rd_i;
    reg_num_t   bus_reg_num_i;
    logic       bus_bytesel_i;
    byte_t      bus_data_i;
    byte_t      bus_data_o;
    logic       vram_sel_o;
    logic       vram_wr_o;
    word_t      vram_addr_o;
    word_t      vram_data_o;
    wrmask_t    vram_wrmask_o;
    logic       vram_ack_i;
    word_t      vram_rdata_i;
    intr_mask_t intr_mask_o;

    logic [31:0] stim_state  = 32'h80c2_d161;
    logic [31:0] delay_state = 32'h80c2_d161;
    word_t       mem [word_t];       // VRAM contents
    word_t       exp_addr_q [$];     // expected VRAM writes
    word_t       exp_data_q [$];
    wrmask_t     cur_mask = WRMASK_RESET;

    `include "tb_ref_model.svh"

    reg_interface_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t mem_read(input word_t a);
        return mem.exists(a) ? mem[a] : (a ^ 16'hA5C3);  // unwritten fill
    endfunction

    function automatic word_t mask_merge(input word_t old, input word_t nw, input wrmask_t m);
        word_t r;
        for (int i = 0; i < 4; i++) begin
            r[4*i +: 4] = m[i] ? nw[4*i +: 4] : old[4*i +: 4];
        end
        return r;
    endfunction

    // acks 1 to 4 cycles after select is seen
    initial begin : vram_model
        int unsigned delay;
        vram_ack_i   = 1'b0;
        vram_rdata_i = '0;
        forever begin
            @(negedge clk);
            vram_ack_i = 1'b0;
            if (vram_sel_o) begin
                delay = lfsr_draw(delay_state, 2);
                repeat (delay) @(negedge clk);
                if (vram_wr_o) begin
                    mem[vram_addr_o] = mask_merge(mem_read(vram_addr_o), vram_data_o,
                                                  vram_wrmask_o);
                end else begin
                    vram_rdata_i = mem_read(vram_addr_o);
                end
                vram_ack_i = 1'b1;
            end
        end
    end

    initial begin : write_compare
        forever begin
            @(negedge clk);
            #2;
            if (vram_sel_o && vram_wr_o && vram_ack_i) begin
                if (exp_addr_q.size() == 0) begin
                    fail_msg("VRAM write seen with no write expected");
                end else begin
                    check_word("vram write addr", exp_addr_q.pop_front(), vram_addr_o);
                    check_word("vram write data", exp_data_q.pop_front(), vram_data_o);
                    check_mask("vram write mask", cur_mask, vram_wrmask_o);
                end
            end
        end
    end

    task automatic host_write(input reg_num_t r, input word_t w);
        @(negedge clk);
        bus_wr_i      = 1'b1;
        bus_reg_num_i = r;
        bus_bytesel_i = 1'b0;
        bus_data_i    = w[15:8];
        @(negedge clk);
        bus_bytesel_i = 1'b1;
        bus_data_i    = w[7:0];
        @(negedge clk);
        bus_wr_i = 1'b0;
    endtask

    task automatic read_byte(input reg_num_t r, input logic sel, input logic strobe,
                             output byte_t b);
        @(negedge clk);
        bus_rd_i      = strobe;
        bus_reg_num_i = r;
        bus_bytesel_i = sel;
        #1 b = bus_data_o;  // combinational readback
    endtask

    // strobe 0 only looks with no DATA side effect
    task automatic host_read(input reg_num_t r, input logic strobe, output word_t w);
        read_byte(r, 1'b0, strobe, w[15:8]);
        read_byte(r, 1'b1, strobe, w[7:0]);
        @(negedge clk);
        bus_rd_i = 1'b0;
    endtask

    task automatic wait_idle(input string name);
        byte_t b;
        int    n;
        read_byte(SYS_CTRL, 1'b1, 1'b0, b);
        check_byte({name, " busy"}, 8'h80, b & 8'h80);  // access pending
        n = 0;
        while (b[7] && n < 50) begin
            read_byte(SYS_CTRL, 1'b1, 1'b0, b);
            n++;
        end
        if (b[7]) begin
            fail_msg({"timeout waiting for busy to clear in ", name});
        end
    endtask

    task automatic readback_chan(input string name, input reg_num_t ir, input reg_num_t ar,
                                 input logic pre_read);
        word_t incr;
        word_t addr;
        word_t w;
        incr = word_t'(lfsr_draw(stim_state, 16));
        addr = word_t'(lfsr_draw(stim_state, 16));
        host_write(ir, incr);
        host_write(ar, addr);
        if (pre_read) begin
            wait_idle(name);
        end
        host_read(ir, 1'b0, w);
        check_word({name, " incr"}, incr, w);
        host_read(ar, 1'b0, w);
        check_word({name, " addr"}, ref_addr(addr, incr, pre_read), w);  // pre-read steps
    endtask

    initial begin : stimulus
        word_t w;
        word_t start;
        word_t incr;
        word_t data;
        word_t rd_keep;
        word_t wr_keep;
        word_t rw_words [$];
        byte_t hi;
        byte_t lo;
        bus_wr_i      = 1'b0;
        bus_rd_i      = 1'b0;
        bus_reg_num_i = reg_num_t'(0);
        bus_bytesel_i = 1'b0;
        bus_data_i    = '0;
        reset_i       = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        // reset values including the timer
        for (int i = 0; i < 16; i++) begin
            host_read(reg_num_t'(i), 1'b0, w);
            check_word($sformatf("reset reg %0d", i),
                       (reg_num_t'(i) == SYS_CTRL) ? 16'h000F : 16'h0000, w);
        end
        check_mask("reset wrmask", WRMASK_RESET, vram_wrmask_o);
        check_mask("reset intr mask", '0, intr_mask_o);
        check_bit("reset vram sel", 1'b0, vram_sel_o);
        check_bit("reset vram wr", 1'b0, vram_wr_o);

        readback_chan("RD regs", RD_INCR, RD_ADDR, 1'b1);
        readback_chan("WR regs", WR_INCR, WR_ADDR, 1'b0);
        readback_chan("RW regs", RW_INCR, RW_ADDR, 1'b1);
        hi = byte_t'(lfsr_draw(stim_state, 8));
        lo = byte_t'(lfsr_draw(stim_state, 8));
        host_write(SYS_CTRL, {hi, lo});
        cur_mask = lo[3:0];
        host_read(SYS_CTRL, 1'b0, w);
        check_word("SYS_CTRL readback", {4'h0, hi[3:0], 4'h0, lo[3:0]}, w);
        check_mask("intr mask port", hi[3:0], intr_mask_o);
        check_mask("wrmask port", lo[3:0], vram_wrmask_o);

        // WR stream
        start = 16'h1000 | word_t'(lfsr_draw(stim_state, 8));
        incr  = word_t'(lfsr_draw(stim_state, 4)) + 16'd1;
        host_write(WR_INCR, incr);
        host_write(WR_ADDR, start);
        for (int k = 0; k < NUM_ACC; k++) begin
            data = word_t'(lfsr_draw(stim_state, 16));
            exp_addr_q.push_back(ref_addr(start, incr, k));
            exp_data_q.push_back(data);
            host_write(DATA, data);
            wait_idle("WR stream");
        end
        host_read(WR_ADDR, 1'b0, wr_keep);
        check_word("WR_ADDR after stream", ref_addr(start, incr, NUM_ACC), wr_keep);

        // RD stream over preloaded words
        start = 16'h4000 | word_t'(lfsr_draw(stim_state, 8));
        incr  = word_t'(lfsr_draw(stim_state, 4)) + 16'd1;
        for (int k = 0; k <= NUM_ACC; k++) begin
            mem[ref_addr(start, incr, k)] = word_t'(lfsr_draw(stim_state, 16));
        end
        host_write(RD_INCR, incr);
        host_write(RD_ADDR, start);
        wait_idle("RD pre-read");
        for (int k = 0; k < NUM_ACC; k++) begin
            host_read(DATA, 1'b1, w);
            check_word("RD stream data", mem_read(ref_addr(start, incr, k)), w);
            wait_idle("RD stream");
        end
        host_read(RD_ADDR, 1'b0, rd_keep);
        check_word("RD_ADDR after stream", ref_addr(start, incr, NUM_ACC + 1), rd_keep);

        // RW channel with full nibble mask
        host_write(SYS_CTRL, 16'h000F);
        cur_mask = 4'hF;
        start = 16'h8000 | word_t'(lfsr_draw(stim_state, 8));
        incr  = word_t'(lfsr_draw(stim_state, 4)) + 16'd1;
        host_write(RW_INCR, incr);
        host_write(RW_ADDR, start);
        wait_idle("RW pre-read");
        for (int k = 0; k < NUM_ACC; k++) begin
            data = word_t'(lfsr_draw(stim_state, 16));
            rw_words.push_back(data);
            exp_addr_q.push_back(ref_addr(start, incr, k + 1));
            exp_data_q.push_back(data);
            host_write(RW_DATA, data);
            wait_idle("RW write");
        end
        host_write(RW_ADDR, ref_addr(start, incr, 1));
        wait_idle("RW re-address");
        for (int k = 0; k < NUM_ACC; k++) begin
            host_read(RW_DATA, 1'b1, w);
            check_word("RW readback", rw_words[k], w);
            wait_idle("RW read");
        end
        host_read(RD_ADDR, 1'b0, w);
        check_word("RD_ADDR after RW", rd_keep, w);
        host_read(WR_ADDR, 1'b0, w);
        check_word("WR_ADDR after RW", wr_keep, w);
        check_word("pending VRAM writes", '0, word_t'(exp_addr_q.size()));

        // timer never goes back and reaches 2
        host_read(TIMER, 1'b0, start);
        for (int i = 0; i < 3 * TICK_DIV; i += 100) begin
            repeat (100) @(negedge clk);
            host_read(TIMER, 1'b0, w);
            if (w < start) begin
                fail_msg($sformatf("timer went backwards from %h to %h", start, w));
            end
            start = w;
        end
        if (start < 16'd2) begin
            fail_msg($sformatf("MISMATCH timer expected >= 0002 actual %h", start));
        end

        $display("Test passed");
        $finish;
    end

endmodule

//--- tick_timer.sv
/*
 * Tenth millisecond timer
 *   clock prescaler and wrapping 16-bit count
 */
`timescale 1ns/1ps

module tick_timer import regif_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,
    output word_t timer_o
);

    localparam int PRESC_W = $clog2(TICK_DIV);

    logic [PRESC_W-1:0] presc;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            presc   <= '0;
            timer_o <= '0;
        end else if (presc == PRESC_W'(TICK_DIV - 1)) begin
            presc   <= '0;
            timer_o <= timer_o + 16'd1;  // wraps
        end else begin
            presc <= presc + 1'b1;
        end
    end

endmodule

//--- vram_addr_channel.sv
/*
 * VRAM address channel
 *   address and increment, written a byte at a time
 *   address step on access ack
 *   last word read through this channel
 */
`timescale 1ns/1ps

module vram_addr_channel import regif_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,
    input  logic  incr_hi_we_i,
    input  logic  incr_lo_we_i,
    input  logic  addr_hi_we_i,
    input  logic  addr_lo_we_i,
    input  byte_t wr_byte_i,
    input  logic  step_i,       // access acked
    input  logic  rdata_we_i,
    input  word_t rdata_i,
    output word_t addr_o,
    output word_t incr_o,
    output word_t rdata_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            addr_o  <= '0;
            incr_o  <= '0;
            rdata_o <= '0;
        end else begin
            if (incr_hi_we_i) begin
                incr_o[15:8] <= wr_byte_i;
            end
            if (incr_lo_we_i) begin
                incr_o[7:0] <= wr_byte_i;
            end

            // step wins over a host byte write
            if (step_i) begin
                addr_o <= addr_o + incr_o;  // wraps at 16 bits
            end else begin
                if (addr_hi_we_i) begin
                    addr_o[15:8] <= wr_byte_i;
                end
                if (addr_lo_we_i) begin
                    addr_o[7:0] <= wr_byte_i;
                end
            end

            if (rdata_we_i) begin
                rdata_o <= rdata_i;
            end
        end
    end

endmodule
